/* logic/macArithPkg.sv */
package macArithPkg;

	localparam int widthX = 8;  // multiplier X
	localparam int widthY = 8;  // multiplicand Y
	localparam int widthA = 20; // augend, accumulator and result

	// host commands, taken from the low two bits of the command word
	typedef enum logic [1:0] {
		OP_MULADD = 2'd0, // X*Y + A
		OP_MULACC = 2'd1, // X*Y + acc
		OP_CLEAR  = 2'd2  // acc and result to zero
	} macOp;

endpackage

/* logic/macBusPkg.sv */
package macBusPkg;

	localparam int busWidth  = 32; // wishbone data
	localparam int addrWidth = 3;  // word address
	localparam int cntWidth  = 16; // completion counter, wraps

	// word addresses of the register map
	typedef enum logic [addrWidth-1:0] {
		REG_X      = 3'd0, // write only
		REG_Y      = 3'd1,
		REG_A      = 3'd2,
		REG_CMD    = 3'd3, // a write here launches the operation
		REG_RESULT = 3'd4, // read only
		REG_STATUS = 3'd5
	} regAddr;

endpackage

/* logic/MulPPGenSgn.sv */
`timescale 1ns/1ps

module MulPPGenSgn #(
	parameter int widthX = 8, // multiplier width
	parameter int widthY = 8  // multiplicand width
) (
	input  logic [widthX-1:0]                       X,
	input  logic [widthY-1:0]                       Y,
	output logic [(widthX+2)*(widthX+widthY)-1:0]   PP // widthX+2 rows of widthX+widthY bits
);

	always_comb begin : ppRows
		logic xb;
		logic yb;
		PP = '0;
		// row i holds X[i]*Y shifted by i
		for (int i = 0; i < widthX; i++) begin
			for (int k = 0; k < widthY; k++) begin
				xb = X[i];
				yb = Y[k];
				if (i == widthX - 1 && k != widthY - 1)
					yb = ~yb; // negative weight of X sign, y side inverted
				if (i != widthX - 1 && k == widthY - 1)
					xb = ~xb; // negative weight of Y sign
				PP[i*(widthX+widthY)+i+k] = xb & yb; // sign*sign stays plain
			end
		end

		// X sign correction row
		PP[widthX*(widthX+widthY)+widthX-1]        = X[widthX-1];
		PP[widthX*(widthX+widthY)+widthX+widthY-2] = ~X[widthX-1];

		// Y sign correction row, constant one in the MSB column
		PP[(widthX+1)*(widthX+widthY)+widthY-1]        = Y[widthY-1];
		PP[(widthX+1)*(widthX+widthY)+widthX+widthY-2] = ~Y[widthY-1];
		PP[(widthX+2)*(widthX+widthY)-1]               = 1'b1;
	end

endmodule

/* logic/Cpr.sv */
`timescale 1ns/1ps

module Cpr #(
	parameter int depth = 4, // column bits
	parameter int speed = 0  // 0 linear chain, 1 tree
) (
	input  logic [depth-1:0] A,  // bits of one column
	input  logic [depth-4:0] CI, // intermediate carries from the column below
	output logic             S,  // column sum
	output logic             C,  // carry into next column
	output logic [depth-4:0] CO  // intermediate carries to next column
);

	logic [depth-3:0] cot; // all full-adder carries, weight of next column

	// full adder, returns {carry, sum}
	function automatic logic [1:0] fullAdd(input logic a, input logic b, input logic ci);
		return {(a & b) | (ci & (a ^ b)), a ^ b ^ ci};
	endfunction

	if (depth < 4) begin : depthCheck
		$error("Cpr: depth must be at least 4");
	end

	if (speed == 0) begin : slowCpr
		logic [depth-3:0] sl; // running sum down the chain

		assign {cot[0], sl[0]} = fullAdd(A[0], A[1], A[2]);
		// each further stage takes one column bit and one incoming carry
		for (genvar i = 1; i < depth - 2; i++) begin : linear
			assign {cot[i], sl[i]} = fullAdd(A[i+2], CI[i-1], sl[i-1]);
		end
		assign S = sl[depth-3];
	end else begin : fastCpr
		// queue of bits still to be added; sums and carries-in join the tail
		logic [3*depth-6:0] f;

		assign f[depth-1:0] = A;
		for (genvar i = 0; i < depth - 2; i++) begin : tree
			assign {cot[i], f[depth+2*i]} = fullAdd(f[3*i], f[3*i+1], f[3*i+2]);
			if (i < depth - 3) begin : carryIn
				assign f[depth+2*i+1] = CI[i];
			end
		end
		assign S = f[3*depth-6]; // last sum out of the queue
	end

	assign CO = cot[depth-4:0];
	assign C  = cot[depth-3];

endmodule

/* logic/AddMopCsv.sv */
`timescale 1ns/1ps

module AddMopCsv #(
	parameter int width = 8, // operand width
	parameter int depth = 4, // operand count
	parameter int speed = 0  // passed to the slices
) (
	input  logic [depth*width-1:0] A, // operands, operand k at k*width
	output logic [width-1:0]       S, // sum vector
	output logic [width-1:0]       C  // carry vector, already weighted
);

	logic [depth*width-1:0]       grp;   // bits grouped per column
	logic [(depth-3)*(width+1)-1:0] chain; // intermediate carries between slices
	logic [width-1:0]             ct;    // slice carries before the shift

	// column i gets bit i of every operand
	for (genvar i = 0; i < width; i++) begin : column
		for (genvar k = 0; k < depth; k++) begin : operand
			assign grp[i*depth+k] = A[k*width+i];
		end
	end

	assign chain[depth-4:0] = '0; // nothing enters the LSB slice

	for (genvar i = 0; i < width; i++) begin : bitSlice
		Cpr #(.depth(depth), .speed(speed)) u_cpr (
			.A (grp[i*depth +: depth]),
			.CI(chain[i*(depth-3) +: depth-3]),
			.S (S[i]),
			.C (ct[i]),
			.CO(chain[(i+1)*(depth-3) +: depth-3]) // top slice spills past width
		);
	end

	assign C = {ct[width-2:0], 1'b0};

endmodule

/* logic/MulAddSgn.sv */
`timescale 1ns/1ps

module MulAddSgn (
	input  logic [macArithPkg::widthX-1:0] X, // multiplier
	input  logic [macArithPkg::widthY-1:0] Y, // multiplicand
	input  logic [macArithPkg::widthA-1:0] A, // augend
	output logic [macArithPkg::widthA-1:0] P  // X*Y + A, wraps at widthA
);
	import macArithPkg::*;

	logic [(widthX+2)*(widthX+widthY)-1:0] pp;    // partial product rows
	logic [(widthX+2)*widthA-1:0]          ppExt; // rows at result width
	logic [widthA-1:0]                     s1;    // compressor sum
	logic [widthA-1:0]                     c1;    // compressor carry
	logic [widthA-1:0]                     s2;    // after augend row
	logic [widthA-1:0]                     c2;
	logic [widthA-2:0]                     t2;    // augend row carries, unshifted
	logic [widthA-1:0]                     rc;    // ripple carries

	MulPPGenSgn #(.widthX(widthX), .widthY(widthY)) u_ppGen (
		.X (X),
		.Y (Y),
		.PP(pp)
	);

	// sign extension: ones above the MSB constant turn +2^(P-1) into -2^(P-1)
	for (genvar r = 0; r < widthX + 2; r++) begin : rowExt
		assign ppExt[r*widthA +: widthA] = {{(widthA-widthX-widthY){r == widthX + 1}},
			pp[r*(widthX+widthY) +: widthX+widthY]};
	end

	AddMopCsv #(.width(widthA), .depth(widthX + 2), .speed(1)) u_csa (
		.A(ppExt),
		.S(s1),
		.C(c1)
	);

	// 3:2 row folds in the augend
	assign s2 = s1 ^ c1 ^ A;
	assign t2 = (s1[widthA-2:0] & c1[widthA-2:0])
		| (A[widthA-2:0] & (s1[widthA-2:0] ^ c1[widthA-2:0]));
	assign c2 = {t2, 1'b0};

	// final ripple add, carry out of the MSB dropped
	assign rc[0] = 1'b0;
	for (genvar i = 0; i < widthA - 1; i++) begin : ripple
		assign rc[i+1] = (s2[i] & c2[i]) | (rc[i] & (s2[i] ^ c2[i]));
	end
	assign P = s2 ^ c2 ^ rc;

endmodule

/* logic/macBusIn.sv */
`timescale 1ns/1ps

module macBusIn (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [macBusPkg::addrWidth-1:0] adr,
	input  logic [macBusPkg::busWidth-1:0]  datIn,
	output logic                            ack,
	output logic [macArithPkg::widthX-1:0]  opX,
	output logic [macArithPkg::widthY-1:0]  opY,
	output logic [macArithPkg::widthA-1:0]  opA,
	output macArithPkg::macOp               cmdOp,
	output logic                            start // with the ack of a REG_CMD write
);
	import macArithPkg::*;
	import macBusPkg::*;

	logic req; // new access, not yet acknowledged

	assign req = cyc & stb & ~ack;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ack   <= 1'b0;
			start <= 1'b0;
			opX   <= '0;
			opY   <= '0;
			opA   <= '0;
			cmdOp <= OP_MULADD;
		end else begin
			ack   <= req; // one cycle, never stalls
			start <= req & we & (regAddr'(adr) == REG_CMD);
			if (req && we) begin
				case (regAddr'(adr))
					REG_X:   opX   <= datIn[widthX-1:0];
					REG_Y:   opY   <= datIn[widthY-1:0];
					REG_A:   opA   <= datIn[widthA-1:0];
					REG_CMD: cmdOp <= macOp'(datIn[1:0]);
					default: ; // read-only or unmapped, ignored
				endcase
			end
		end
	end

	// master keeps the strobe up until it has seen ack
	assert property (@(posedge clk) disable iff (!rstN) ack |-> (cyc && stb));

endmodule

/* logic/macEngine.sv */
`timescale 1ns/1ps

module macEngine (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic [macArithPkg::widthX-1:0] opX,
	input  logic [macArithPkg::widthY-1:0] opY,
	input  logic [macArithPkg::widthA-1:0] opA,
	input  macArithPkg::macOp              cmdOp,
	input  logic                           start,
	output logic [macArithPkg::widthA-1:0] result,
	output logic                           done
);
	import macArithPkg::*;

	logic [widthX-1:0] s1X;     // stage 1 operands
	logic [widthY-1:0] s1Y;
	logic [widthA-1:0] s1A;
	macOp              s1Op;
	logic              s1Valid;
	logic [widthA-1:0] acc;     // running accumulator
	logic [widthA-1:0] augend;
	logic [widthA-1:0] prod;    // X*Y + augend

	always_ff @(posedge clk) begin
		if (start) begin
			s1X  <= opX;
			s1Y  <= opY;
			s1A  <= opA;
			s1Op <= cmdOp;
		end
	end

	assign augend = (s1Op == OP_MULACC) ? acc : s1A;

	MulAddSgn u_mulAdd (
		.X(s1X),
		.Y(s1Y),
		.A(augend),
		.P(prod)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			done    <= 1'b0;
			acc     <= '0;
			result  <= '0;
		end else begin
			s1Valid <= start;
			done    <= s1Valid; // two cycles after start
			if (s1Valid) begin
				case (s1Op)
					OP_MULADD, OP_MULACC: begin
						acc    <= prod;
						result <= prod;
					end
					OP_CLEAR: begin
						acc    <= '0;
						result <= '0;
					end
					default: ; // illegal code keeps the state
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		s1Valid |-> (s1Op inside {OP_MULADD, OP_MULACC, OP_CLEAR}));

endmodule

/* logic/macBusOut.sv */
`timescale 1ns/1ps

module macBusOut (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic [macBusPkg::addrWidth-1:0] adr,
	input  logic [macArithPkg::widthA-1:0]  result,
	input  logic                            done,
	output logic [macBusPkg::busWidth-1:0]  datOut // valid while ack is high
);
	import macArithPkg::*;
	import macBusPkg::*;

	logic [widthA-1:0]   resReg; // last completed result
	logic [cntWidth-1:0] count;  // completed commands, CLEAR included

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resReg <= '0;
			count  <= '0;
		end else if (done) begin
			resReg <= result;
			count  <= count + 1'b1; // wraps
		end
	end

	// read mux straight off the address
	always_comb begin
		case (regAddr'(adr))
			REG_RESULT: datOut = {{(busWidth-widthA){resReg[widthA-1]}}, resReg};
			REG_STATUS: datOut = {{(busWidth-cntWidth){1'b0}}, count};
			default:    datOut = '0; // write-only and unmapped read as zero
		endcase
	end

endmodule

/* logic/macTop.sv */
`timescale 1ns/1ps

module macTop (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [macBusPkg::addrWidth-1:0] adr,
	input  logic [macBusPkg::busWidth-1:0]  datIn,
	output logic                            ack,
	output logic [macBusPkg::busWidth-1:0]  datOut
);
	import macArithPkg::*;

	logic [widthX-1:0] opX;
	logic [widthY-1:0] opY;
	logic [widthA-1:0] opA;
	macOp              cmdOp;
	logic              start;  // launch pulse
	logic [widthA-1:0] result;
	logic              done;   // completion pulse

	macBusIn u_busIn (
		.clk  (clk),
		.rstN (rstN),
		.cyc  (cyc),
		.stb  (stb),
		.we   (we),
		.adr  (adr),
		.datIn(datIn),
		.ack  (ack),
		.opX  (opX),
		.opY  (opY),
		.opA  (opA),
		.cmdOp(cmdOp),
		.start(start)
	);

	macEngine u_engine (
		.clk   (clk),
		.rstN  (rstN),
		.opX   (opX),
		.opY   (opY),
		.opA   (opA),
		.cmdOp (cmdOp),
		.start (start),
		.result(result),
		.done  (done)
	);

	macBusOut u_busOut (
		.clk   (clk),
		.rstN  (rstN),
		.adr   (adr),
		.result(result),
		.done  (done),
		.datOut(datOut)
	);

endmodule

/* sim/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs = 100 // full clock period
) (
	output logic clk
);

	initial clk = 1'b0;
	always #(periodNs / 2.0) clk = ~clk; // 50 % duty

endmodule

/* sim/tbTop.sv */
`timescale 1ns/1ps

module tbTop;

	localparam logic [2:0]  addrX = 3'd0;
	localparam logic [2:0]  addrY = 3'd1;
	localparam logic [2:0]  addrA = 3'd2;
	localparam logic [2:0]  addrCmd = 3'd3;
	localparam logic [2:0]  addrResult = 3'd4;
	localparam logic [2:0]  addrStatus = 3'd5;
	localparam logic [1:0]  opMulAdd = 2'd0;
	localparam logic [1:0]  opMulAcc = 2'd1;
	localparam logic [1:0]  opClear = 2'd2;
	localparam logic [31:0] lfsrSeed = 32'h36d2_a47e;
	localparam logic [31:0] lfsrTaps = 32'h8020_0003; // maximal length taps for a right shift
	localparam int numRandom = 200;
	localparam int numSeq = 3;      // MULACC runs
	localparam int seqLen = 10;
	localparam int numClear = 2;
	localparam int numCmds = 3 + numRandom + numSeq * (1 + seqLen) + 2 * numClear;
	localparam int plannedAccesses = 2 + 6 * numCmds + 5; // 6 accesses per command
	localparam int timeoutCycles = plannedAccesses * 10 + 100;

	logic        clk;
	logic        rstN;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [2:0]  adr;
	logic [31:0] datIn;
	logic        ack;
	logic [31:0] datOut;
	logic        checkRead; // current access is a read with a known answer
	logic [31:0] expData;
	logic [31:0] lfsrState;
	logic [19:0] modelAcc;    // reference accumulator
	logic [15:0] modelCount;  // reference completion count
	int          accessCount;
	int          ackCount;

	tbClock #(.periodNs(100)) u_clock (.clk(clk));

	macTop u_macTop (
		.clk   (clk),
		.rstN  (rstN),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.datIn (datIn),
		.ack   (ack),
		.datOut(datOut)
	);

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	// galois lfsr stepped once per bit handed out
	function automatic logic [31:0] nextBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrTaps) : (lfsrState >> 1);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// signed X*Y plus augend modulo 2^20
	function automatic logic [19:0] mulAddRef(input logic [7:0] x, input logic [7:0] y,
			input logic [19:0] a);
		int full;
		full = int'($signed(x)) * int'($signed(y)) + int'(a);
		return full[19:0];
	endfunction

	// one classic cycle with the strobe held through the edge that samples ack
	task automatic busAccess(input logic wr, input logic [2:0] addr, input logic [31:0] wdata,
			input logic chk, input logic [31:0] exp);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = addr;
		datIn = wdata;
		checkRead = chk;
		expData = exp;
		accessCount++;
		do @(negedge clk); while (!ack); // watchdog catches a missing ack
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		checkRead = 1'b0;
	endtask

	task automatic runCommand(input logic [1:0] op, input logic [7:0] x, input logic [7:0] y,
			input logic [19:0] a);
		logic [19:0] r;
		busAccess(1'b1, addrX, {{24{x[7]}}, x}, 1'b0, '0);
		busAccess(1'b1, addrY, {{24{y[7]}}, y}, 1'b0, '0);
		busAccess(1'b1, addrA, {{12{a[19]}}, a}, 1'b0, '0);
		busAccess(1'b1, addrCmd, {30'd0, op}, 1'b0, '0);
		case (op)
			opMulAdd: r = mulAddRef(x, y, a);
			opMulAcc: r = mulAddRef(x, y, modelAcc);
			default:  r = '0; // clear
		endcase
		modelAcc = r;
		modelCount++;
		repeat (3) @(negedge clk); // command ack to readable result
		busAccess(1'b0, addrResult, '0, 1'b1, {{12{r[19]}}, r});
		busAccess(1'b0, addrStatus, '0, 1'b1, {16'd0, modelCount});
	endtask

	task automatic runRandom(input logic [1:0] op);
		logic [7:0]  x;
		logic [7:0]  y;
		logic [19:0] a;
		x = nextBits(8);
		y = nextBits(8);
		a = nextBits(20);
		runCommand(op, x, y, a);
	endtask

	always @(posedge clk) begin
		if (!rstN)
			ackCount <= 0;
		else if (ack)
			ackCount <= ackCount + 1;
	end

	readValue: assert property (@(posedge clk) disable iff (!rstN)
		(ack && checkRead) |-> (datOut == expData))
		else stopOnError($sformatf("ERROR at %0t: read of address %0d gave %h, expected %h",
			$time, $sampled(adr), $sampled(datOut), $sampled(expData)));

	ackSingle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
		else stopOnError("ack stayed high for two cycles in a row");

	ackIdle: assert property (@(posedge clk) disable iff (!rstN) !(cyc && stb) |-> !ack)
		else stopOnError("ack was raised while no access was in progress");

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		stopOnError($sformatf("simulation timed out after %0d cycles", timeoutCycles));
	end

	initial begin
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		checkRead = 1'b0;
		expData = '0;
		lfsrState = lfsrSeed;
		modelAcc = '0;
		modelCount = '0;
		accessCount = 0;
		repeat (4) @(negedge clk);
		rstN = 1'b1;

		busAccess(1'b0, addrResult, '0, 1'b1, '0); // zero right after reset
		busAccess(1'b0, addrStatus, '0, 1'b1, '0);

		runCommand(opMulAdd, 8'h80, 8'h80, 20'h7ffff); // wraps past the top
		runCommand(opMulAdd, 8'h80, 8'h7f, 20'h80000);
		runCommand(opMulAdd, 8'h00, 8'h00, 20'h00000);
		for (int i = 0; i < numRandom; i++)
			runRandom(opMulAdd);

		for (int s = 0; s < numSeq; s++) begin
			runRandom(opMulAdd); // random starting acc
			for (int j = 0; j < seqLen; j++)
				runRandom(opMulAcc);
		end

		for (int c = 0; c < numClear; c++) begin
			runRandom(opClear);
			runRandom(opMulAcc); // plain X*Y after clear
		end

		busAccess(1'b1, addrResult, 32'hdead_beef, 1'b0, '0); // read-only register ignores it
		busAccess(1'b1, addrStatus, 32'h1234_5678, 1'b0, '0);
		busAccess(1'b0, addrResult, '0, 1'b1, {{12{modelAcc[19]}}, modelAcc});
		busAccess(1'b0, addrStatus, '0, 1'b1, {16'd0, modelCount});
		busAccess(1'b0, addrX, '0, 1'b1, '0); // write-only reads zero

		if (ackCount == accessCount) begin
			$display("All checks passed");
			$finish;
		end else begin
			stopOnError($sformatf("ERROR at %0t: %0d acks seen for %0d accesses",
				$time, ackCount, accessCount));
		end
	end

endmodule

/* list.f */
logic/macArithPkg.sv
logic/macBusPkg.sv
logic/MulPPGenSgn.sv
logic/Cpr.sv
logic/AddMopCsv.sv
logic/MulAddSgn.sv
logic/macBusIn.sv
logic/macEngine.sv
logic/macBusOut.sv
logic/macTop.sv
sim/tbClock.sv
sim/tbTop.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = tbTop
FILELIST  = list.f
OBJDIR    = obj_dir
PASS      = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)
